/* bench/scratchpad_checker.sv */
`timescale 1ns/10ps
`include "scratchpad_defs.svh"

module scratchpad_checker (
  input logic                            clk,
  input logic                            rst_n,
  input logic                            ld_addr_valid,
  input logic                            ld_addr_ready,
  input logic [`SP_TAG_W+`SP_ADDR_W-1:0] ld_addr_data,
  input logic                            ld_data_valid,
  input logic                            ld_data_ready,
  input logic [`SP_TAG_W+`SP_ELEM_W-1:0] ld_data_data,
  input logic                            ld_done_valid,
  input logic                            ld_done_ready,
  input logic [`SP_TAG_W-1:0]            ld_done_data,
  input logic                            st_addr_valid,
  input logic                            st_addr_ready,
  input logic [`SP_TAG_W+`SP_ADDR_W-1:0] st_addr_data,
  input logic                            st_data_valid,
  input logic                            st_data_ready,
  input logic [`SP_TAG_W+`SP_ELEM_W-1:0] st_data_data,
  input logic                            st_done_valid,
  input logic                            st_done_ready,
  input logic [`SP_TAG_W-1:0]            st_done_data,
  input logic                            error_valid,
  input logic [15:0]                     error_code
);
  import scratchpad_pkg::*;

  int       value_errors = 0;
  int       rule_errors = 0;
  string    test_name = "reset";
  elem_t    exp_load;
  logic     exp_load_set = 1'b0;
  elem_t    shadow [`SP_MEM_DEPTH];
  logic     shadow_ok [`SP_MEM_DEPTH];
  mem_idx_t addr_buf [`SP_ST_PORTS][`SP_LSQ_DEPTH];
  elem_t    data_buf [`SP_ST_PORTS][`SP_LSQ_DEPTH];
  int       addr_cnt [`SP_ST_PORTS];
  int       data_cnt [`SP_ST_PORTS];
  logic     err_seen;
  logic [15:0] err_held;

  initial begin
    for (int i = 0; i < `SP_MEM_DEPTH; i++) shadow_ok[i] = 1'b0;
  end

  task automatic set_test(input string name);
    test_name = name;
  endtask

  task automatic expect_load(input elem_t value);
    exp_load     = value;
    exp_load_set = 1'b1;
  endtask

  task automatic compare_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic rule_fail(input string what);
    $display("%s: %s", test_name, what);
    rule_errors++;
  endtask

  task automatic check_error(input string name, input logic [15:0] exp);
    compare_value(name, exp, error_valid ? error_code : 16'd0);
  endtask

  function automatic int pending();
    int sum;
    sum = 0;
    for (int i = 0; i < `SP_ST_PORTS; i++) sum += addr_cnt[i] + data_cnt[i];
    return sum;
  endfunction

  // --------------------
  // Everything is sampled mid-cycle, a valid and ready pair seen here fires on the next edge
  always @(negedge clk) begin : watch
    tag_t     t;
    tag_t     at;
    tag_t     dt;
    mem_idx_t idx;
    int       low;
    if (!rst_n) begin
      for (int i = 0; i < `SP_ST_PORTS; i++) begin
        addr_cnt[i] = 0;
        data_cnt[i] = 0;
      end
      err_seen = 1'b0;
    end else begin
      // Load side rules
      t   = ld_addr_data[`SP_ADDR_W +: `SP_TAG_W];
      idx = mem_idx_t'(ld_addr_data[`SP_ADDR_W-1:0]);
      if (t >= `SP_LD_PORTS) begin
        if (ld_addr_ready || ld_data_valid || ld_done_valid)
          rule_fail("load with an illegal tag was offered a handshake");
      end else begin
        if (ld_addr_ready != (ld_data_ready && ld_done_ready))
          rule_fail("ld_addr_ready ignores the data or done back-pressure");
        if (ld_addr_valid && ((ld_done_valid != ld_data_ready) || (ld_data_valid != ld_done_ready)))
          rule_fail("load data and done valids are not aligned");
      end
      if (ld_addr_valid && ld_addr_ready) begin
        if (!(ld_data_valid && ld_done_valid)) rule_fail("load accepted without both completions");
        compare_value({test_name, " done tag"}, t, ld_done_data);
        compare_value({test_name, " data tag"}, t, ld_data_data[`SP_ELEM_W +: `SP_TAG_W]);
        if (shadow_ok[idx])
          compare_value({test_name, " shadow"}, shadow[idx], ld_data_data[`SP_ELEM_W-1:0]);
        if (exp_load_set)
          compare_value(test_name, exp_load, ld_data_data[`SP_ELEM_W-1:0]);
        exp_load_set = 1'b0;
      end

      // Store ready against the modelled queue depth
      at = st_addr_data[`SP_ADDR_W +: `SP_TAG_W];
      dt = st_data_data[`SP_ELEM_W +: `SP_TAG_W];
      if (at >= `SP_ST_PORTS) begin
        if (st_addr_ready) rule_fail("store address with an illegal tag shows ready");
      end else if (st_addr_ready != (addr_cnt[at] < `SP_LSQ_DEPTH)) begin
        rule_fail("st_addr_ready disagrees with the address queue depth");
      end
      if (dt >= `SP_ST_PORTS) begin
        if (st_data_ready) rule_fail("store data with an illegal tag shows ready");
      end else if (st_data_ready != (data_cnt[dt] < `SP_LSQ_DEPTH)) begin
        rule_fail("st_data_ready disagrees with the data queue depth");
      end

      // Pairing, lowest tag with both queues filled
      low = -1;
      for (int i = `SP_ST_PORTS - 1; i >= 0; i--)
        if (addr_cnt[i] > 0 && data_cnt[i] > 0) low = i;
      if (st_done_valid != (low >= 0)) begin
        rule_fail("st_done_valid disagrees with the queue model");
      end else if (st_done_valid) begin
        compare_value({test_name, " st_done tag"}, low, st_done_data);
        if (st_done_ready) begin
          shadow[addr_buf[low][0]]    = data_buf[low][0];
          shadow_ok[addr_buf[low][0]] = 1'b1;
          for (int k = 0; k < `SP_LSQ_DEPTH - 1; k++) begin
            addr_buf[low][k] = addr_buf[low][k+1];
            data_buf[low][k] = data_buf[low][k+1];
          end
          addr_cnt[low]--;
          data_cnt[low]--;
        end
      end

      if (st_addr_valid && st_addr_ready && at < `SP_ST_PORTS) begin
        addr_buf[at][addr_cnt[at]] = mem_idx_t'(st_addr_data[`SP_ADDR_W-1:0]);
        addr_cnt[at]++;
      end
      if (st_data_valid && st_data_ready && dt < `SP_ST_PORTS) begin
        data_buf[dt][data_cnt[dt]] = st_data_data[`SP_ELEM_W-1:0];
        data_cnt[dt]++;
      end

      // First error stays put
      if (err_seen && (!error_valid || error_code !== err_held))
        rule_fail("error report changed after it was captured");
      if (error_valid && !err_seen) begin
        err_seen = 1'b1;
        err_held = error_code;
      end
    end
  end

endmodule

/* bench/scratchpad_patterns.txt */
# command tag index element expect (hex)
# wait: index is a cycle count and expect an error code; stall: index 1 holds st_done_ready low
store 0 05 11112222 0
load 0 05 0 11112222
store_addr_only 1 07 0 1
store_addr_only 2 08 0 1
store_data_only 2 0 aaaa0002 1
store_data_only 1 0 bbbb0001 1
store_addr_only 1 09 0 1
store_data_only 1 0 cccc0001 1
load 1 07 0 bbbb0001
load 2 08 0 aaaa0002
load 0 09 0 cccc0001
stall 0 1 0 0
store 0 05 eeee0000 0
load 2 05 0 11112222
store 0 06 66660000 0
store 0 07 77770000 0
store 0 08 88880000 0
store_addr_only 0 09 0 0
stall 0 0 0 0
load 0 05 0 eeee0000
load 1 08 0 88880000
bad_tag 3 05 0 1
wait 0 04 0 1
reset 0 0 0 0
store_addr_only 1 0a 0 1
wait 0 20 0 0
wait 0 02 0 2

/* bench/tb_scratchpad_mem.sv */
`timescale 1ns/10ps
`include "scratchpad_defs.svh"

module tb_scratchpad_mem;

  logic                            clk;
  logic                            rst_n;
  logic                            ld_addr_valid;
  logic                            ld_addr_ready;
  logic [`SP_TAG_W+`SP_ADDR_W-1:0] ld_addr_data;
  logic                            ld_data_valid;
  logic                            ld_data_ready;
  logic [`SP_TAG_W+`SP_ELEM_W-1:0] ld_data_data;
  logic                            ld_done_valid;
  logic                            ld_done_ready;
  logic [`SP_TAG_W-1:0]            ld_done_data;
  logic                            st_addr_valid;
  logic                            st_addr_ready;
  logic [`SP_TAG_W+`SP_ADDR_W-1:0] st_addr_data;
  logic                            st_data_valid;
  logic                            st_data_ready;
  logic [`SP_TAG_W+`SP_ELEM_W-1:0] st_data_data;
  logic                            st_done_valid;
  logic                            st_done_ready;
  logic [`SP_TAG_W-1:0]            st_done_data;
  logic                            error_valid;
  logic [15:0]                     error_code;

  logic [15:0] lfsr = 16'd28450;
  logic        stall_on = 1'b0;
  int          cycles = 0;
  int          cycle_limit = 0;
  int          pattern_errors = 0;
  string       cmd_q [$];
  logic [31:0] tag_q [$];
  logic [31:0] idx_q [$];
  logic [31:0] elem_q [$];
  logic [31:0] exp_q [$];

  scratchpad_mem dut_i (.*);
  scratchpad_checker chk_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Galois LFSR, one step per bit
  function automatic logic next_bit();
    next_bit = lfsr[0];
    lfsr     = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
  endfunction

  function automatic int random_bits(input int n);
    random_bits = 0;
    for (int i = 0; i < n; i++) random_bits = (random_bits << 1) | next_bit();
  endfunction

  // --------------------
  // Stimulus helpers, all entered and left 2 ns after a rising edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (16) step();
    rst_n = 1'b1;
  endtask

  task automatic send_addr(input logic [31:0] tag, input logic [31:0] idx);
    st_addr_data  = {tag[`SP_TAG_W-1:0], idx[`SP_ADDR_W-1:0]};
    st_addr_valid = 1'b1;
    do @(negedge clk); while (!st_addr_ready);
    step();
    st_addr_valid = 1'b0;
  endtask

  task automatic send_data(input logic [31:0] tag, input logic [31:0] elem);
    st_data_data  = {tag[`SP_TAG_W-1:0], elem[`SP_ELEM_W-1:0]};
    st_data_valid = 1'b1;
    do @(negedge clk); while (!st_data_ready);
    step();
    st_data_valid = 1'b0;
  endtask

  task automatic issue_load(input logic [31:0] tag, input logic [31:0] idx, input logic [31:0] exp);
    // Stores already sent must have landed unless the done channel is held
    while (!stall_on && chk_i.pending() != 0) step();
    chk_i.expect_load(exp[`SP_ELEM_W-1:0]);
    ld_addr_data  = {tag[`SP_TAG_W-1:0], idx[`SP_ADDR_W-1:0]};
    ld_addr_valid = 1'b1;
    do @(negedge clk); while (!ld_addr_ready);
    step();
    ld_addr_valid = 1'b0;
  endtask

  // Random back-pressure on the done and load data channels
  initial begin : ready_jitter
    forever begin
      step();
      st_done_ready = !stall_on && (next_bit() || next_bit());
      ld_data_ready = next_bit() || next_bit();
    end
  end

  initial begin : watchdog
    while (cycle_limit == 0 || cycles <= cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, a handshake never completed", cycles);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : run
    int                fd;
    int                total;
    reg [8*96-1:0]     line;
    reg [8*24-1:0]     word;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       c;
    logic [31:0]       e;
    string             cmd;
    string             name;
    rst_n         = 1'b0;
    ld_addr_valid = 1'b0;
    ld_addr_data  = '0;
    ld_data_ready = 1'b1;
    ld_done_ready = 1'b1;
    st_addr_valid = 1'b0;
    st_addr_data  = '0;
    st_data_valid = 1'b0;
    st_data_data  = '0;
    st_done_ready = 1'b1;
    fd = $fopen("bench/scratchpad_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open bench/scratchpad_patterns.txt");
      $display("=== FAIL ===");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        if ($fgets(line, fd) > 0 && $sscanf(line, "%s %h %h %h %h", word, a, b, c, e) == 5) begin
          cmd_q.push_back($sformatf("%0s", word));
          tag_q.push_back(a);
          idx_q.push_back(b);
          elem_q.push_back(c);
          exp_q.push_back(e);
        end
      end
      $fclose(fd);
      cycle_limit = cmd_q.size() * 64 + 4 * `SP_DL_TIMEOUT;

      #2;
      apply_reset();
      foreach (cmd_q[i]) begin
        cmd  = cmd_q[i];
        name = $sformatf("%s_%0d", cmd, i + 1);
        chk_i.set_test(name);
        if (cmd == "store" || cmd == "store_data_only" || cmd == "load")
          repeat (random_bits(2)) step();
        if (cmd == "store") begin
          send_addr(tag_q[i], idx_q[i]);
          send_data(tag_q[i], elem_q[i]);
        end else if (cmd == "store_addr_only") begin
          if (exp_q[i] != 0) begin
            send_addr(tag_q[i], idx_q[i]);
          end else begin
            // Lane is full, the address must sit unaccepted
            st_addr_data  = {tag_q[i][`SP_TAG_W-1:0], idx_q[i][`SP_ADDR_W-1:0]};
            st_addr_valid = 1'b1;
            repeat (4) step();
            chk_i.compare_value(name, 64'd0, st_addr_ready);
            st_addr_valid = 1'b0;
          end
        end else if (cmd == "store_data_only") begin
          send_data(tag_q[i], elem_q[i]);
        end else if (cmd == "load") begin
          issue_load(tag_q[i], idx_q[i], exp_q[i]);
        end else if (cmd == "stall") begin
          stall_on      = idx_q[i][0];
          st_done_ready = !stall_on;
        end else if (cmd == "bad_tag") begin
          ld_addr_data  = {tag_q[i][`SP_TAG_W-1:0], idx_q[i][`SP_ADDR_W-1:0]};
          ld_addr_valid = 1'b1;
          repeat (3) step();
          ld_addr_valid = 1'b0;
          step();
          chk_i.check_error(name, exp_q[i][15:0]);
        end else if (cmd == "reset") begin
          apply_reset();
        end else if (cmd == "wait") begin
          repeat (idx_q[i]) step();
          chk_i.check_error(name, exp_q[i][15:0]);
        end else begin
          $display("Unknown command %s in pattern line %0d", cmd, i + 1);
          pattern_errors++;
        end
      end

      repeat (2) step();
      total = chk_i.value_errors + chk_i.rule_errors + pattern_errors;
      $display("Errors: %0d value mismatches, %0d protocol violations, %0d pattern errors",
               chk_i.value_errors, chk_i.rule_errors, pattern_errors);
      if (total == 0) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
      $finish;
    end
  end

endmodule

/* scratchpad_mem.f */
+incdir+src
src/scratchpad_pkg.sv
src/scratchpad_ifs.sv
src/store_router.sv
src/store_lane_queue.sv
src/store_pair_arbiter.sv
src/scratchpad_array.sv
src/error_latch.sv
src/scratchpad_mem.sv
bench/scratchpad_checker.sv
bench/tb_scratchpad_mem.sv

/* src/error_latch.sv */
`timescale 1ns/10ps

module error_latch (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ld_tag_oob,
  input  logic                      st_tag_oob,
  input  logic                      deadlock,
  output logic                      error_valid,
  output scratchpad_pkg::err_code_t error_code
);
  import scratchpad_pkg::*;

  err_code_t code_next;

  // Tag errors outrank deadlock
  always_comb begin
    code_next = err_none;
    if (ld_tag_oob || st_tag_oob) code_next = err_tag_oob;
    else if (deadlock)            code_next = err_store_deadlock;
  end

  // Sticky, first error only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error_valid <= 1'b0;
      error_code  <= err_none;
    end else if (!error_valid && (code_next != err_none)) begin
      error_valid <= 1'b1;
      error_code  <= code_next;
    end
  end

  a_err_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    error_valid |=> error_valid && $stable(error_code));

endmodule

/* src/scratchpad_array.sv */
`timescale 1ns/10ps
`include "scratchpad_defs.svh"

module scratchpad_array (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            wr_en,
  input  scratchpad_pkg::mem_idx_t        wr_idx,
  input  scratchpad_pkg::elem_t           wr_elem,
  input  logic                            ld_addr_valid,
  output logic                            ld_addr_ready,
  input  logic [`SP_TAG_W+`SP_ADDR_W-1:0] ld_addr_data,
  output logic                            ld_data_valid,
  input  logic                            ld_data_ready,
  output logic [`SP_TAG_W+`SP_ELEM_W-1:0] ld_data_data,
  output logic                            ld_done_valid,
  input  logic                            ld_done_ready,
  output scratchpad_pkg::tag_t            ld_done_data,
  output logic                            ld_tag_oob
);
  import scratchpad_pkg::*;

  elem_t    mem [`SP_MEM_DEPTH];
  tag_t     ld_tag;
  mem_idx_t ld_idx;
  logic     ld_tag_ok;

  // Writes are held off while reset is asserted
  always_ff @(posedge clk) begin
    if (wr_en && rst_n) mem[wr_idx] <= wr_elem;
  end

  // --------------------
  // Load path, one aligned data/done completion
  assign ld_tag    = ld_addr_data[`SP_ADDR_W +: `SP_TAG_W];
  assign ld_idx    = mem_idx_t'(ld_addr_data[`SP_ADDR_W-1:0]);
  assign ld_tag_ok = ld_tag < tag_t'(`SP_LD_PORTS);

  assign ld_addr_ready = ld_tag_ok && ld_data_ready && ld_done_ready;
  assign ld_data_valid = ld_addr_valid && ld_tag_ok && ld_done_ready;
  assign ld_done_valid = ld_addr_valid && ld_tag_ok && ld_data_ready;

  assign ld_data_data = {ld_tag, mem[ld_idx]};
  assign ld_done_data = ld_tag;
  assign ld_tag_oob   = ld_addr_valid && !ld_tag_ok;

endmodule

/* src/scratchpad_defs.svh */
`ifndef SCRATCHPAD_DEFS_SVH
`define SCRATCHPAD_DEFS_SVH

// Field widths
`define SP_ADDR_W      16
`define SP_ELEM_W      32
`define SP_TAG_W       2

// Logical port counts carried by the tag field
`define SP_LD_PORTS    3
`define SP_ST_PORTS    3

// Storage sizes
`define SP_LSQ_DEPTH   4
`define SP_MEM_DEPTH   64

// Cycles a half-filled store lane may wait
`define SP_DL_TIMEOUT  32

`endif

/* src/scratchpad_ifs.sv */
`timescale 1ns/10ps

// Enqueue side of one store lane
interface lane_enq_if;
  import scratchpad_pkg::*;

  logic     addr_enq;
  mem_idx_t addr_idx;
  logic     data_enq;
  elem_t    data_elem;
  logic     addr_full;
  logic     data_full;

  modport router (output addr_enq, addr_idx, data_enq, data_elem,
                  input  addr_full, data_full);
  modport lane   (input  addr_enq, addr_idx, data_enq, data_elem,
                  output addr_full, data_full);
endinterface

// Pairing side of one store lane
interface lane_pair_if;
  import scratchpad_pkg::*;

  logic     pair_req;
  mem_idx_t head_idx;
  elem_t    head_elem;
  logic     deadlock_hit;
  logic     pop;

  modport lane    (output pair_req, head_idx, head_elem, deadlock_hit, input pop);
  modport arbiter (input pair_req, head_idx, head_elem, deadlock_hit, output pop);
endinterface

/* src/scratchpad_mem.sv */
`timescale 1ns/10ps
`include "scratchpad_defs.svh"

module scratchpad_mem (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            ld_addr_valid,
  output logic                            ld_addr_ready,
  input  logic [`SP_TAG_W+`SP_ADDR_W-1:0] ld_addr_data,
  output logic                            ld_data_valid,
  input  logic                            ld_data_ready,
  output logic [`SP_TAG_W+`SP_ELEM_W-1:0] ld_data_data,
  output logic                            ld_done_valid,
  input  logic                            ld_done_ready,
  output logic [`SP_TAG_W-1:0]            ld_done_data,
  input  logic                            st_addr_valid,
  output logic                            st_addr_ready,
  input  logic [`SP_TAG_W+`SP_ADDR_W-1:0] st_addr_data,
  input  logic                            st_data_valid,
  output logic                            st_data_ready,
  input  logic [`SP_TAG_W+`SP_ELEM_W-1:0] st_data_data,
  output logic                            st_done_valid,
  input  logic                            st_done_ready,
  output logic [`SP_TAG_W-1:0]            st_done_data,
  output logic                            error_valid,
  output logic [15:0]                     error_code
);

  logic                     wr_en;
  scratchpad_pkg::mem_idx_t wr_idx;
  scratchpad_pkg::elem_t    wr_elem;
  logic                     ld_tag_oob;
  logic                     st_tag_oob;
  logic                     deadlock;

  lane_enq_if  enq_if  [`SP_ST_PORTS] ();
  lane_pair_if pair_if [`SP_ST_PORTS] ();

  // --------------------
  // Store side
  store_router router_i (
    .st_addr_valid, .st_addr_ready, .st_addr_data,
    .st_data_valid, .st_data_ready, .st_data_data,
    .st_tag_oob, .lanes(enq_if)
  );

  for (genvar i = 0; i < `SP_ST_PORTS; i++) begin : g_lane
    store_lane_queue lane_i (.clk, .rst_n, .enq(enq_if[i]), .pair(pair_if[i]));
  end

  store_pair_arbiter arbiter_i (
    .st_done_ready, .st_done_valid, .st_done_data,
    .wr_en, .wr_idx, .wr_elem, .deadlock, .lanes(pair_if)
  );

  // --------------------
  // Array, load side and errors
  scratchpad_array array_i (
    .clk, .rst_n, .wr_en, .wr_idx, .wr_elem,
    .ld_addr_valid, .ld_addr_ready, .ld_addr_data,
    .ld_data_valid, .ld_data_ready, .ld_data_data,
    .ld_done_valid, .ld_done_ready, .ld_done_data,
    .ld_tag_oob
  );

  error_latch error_i (
    .clk, .rst_n, .ld_tag_oob, .st_tag_oob, .deadlock, .error_valid, .error_code
  );

endmodule

/* src/scratchpad_pkg.sv */
`include "scratchpad_defs.svh"

package scratchpad_pkg;

  typedef logic [`SP_ELEM_W-1:0] elem_t;
  typedef logic [$clog2(`SP_MEM_DEPTH)-1:0] mem_idx_t;
  typedef logic [`SP_TAG_W-1:0] tag_t;

  // Error channel opcode
  typedef enum logic [15:0] {
    err_none           = 16'd0,
    err_tag_oob        = 16'd1,
    err_store_deadlock = 16'd2
  } err_code_t;

endpackage

/* src/store_lane_queue.sv */
`timescale 1ns/10ps
`include "scratchpad_defs.svh"

module store_lane_queue (
  input  logic     clk,
  input  logic     rst_n,
  lane_enq_if.lane enq,
  lane_pair_if.lane pair
);
  import scratchpad_pkg::*;

  localparam int QW = $clog2(`SP_LSQ_DEPTH);
  localparam int CW = $clog2(`SP_DL_TIMEOUT + 1);

  mem_idx_t      addr_q [`SP_LSQ_DEPTH];
  elem_t         data_q [`SP_LSQ_DEPTH];
  logic [QW-1:0] addr_wp;
  logic [QW-1:0] addr_rp;
  logic [QW-1:0] data_wp;
  logic [QW-1:0] data_rp;
  logic [QW:0]   addr_cnt;
  logic [QW:0]   data_cnt;
  logic          addr_empty;
  logic          data_empty;
  logic [CW-1:0] dl_cnt;

  function automatic logic [QW-1:0] ptr_inc(input logic [QW-1:0] p);
    ptr_inc = (p == QW'(`SP_LSQ_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // --------------------
  // Queue storage and pointers
  always_ff @(posedge clk) begin
    if (enq.addr_enq) addr_q[addr_wp] <= enq.addr_idx;
    if (enq.data_enq) data_q[data_wp] <= enq.data_elem;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_wp  <= '0;
      addr_rp  <= '0;
      addr_cnt <= '0;
      data_wp  <= '0;
      data_rp  <= '0;
      data_cnt <= '0;
    end else begin
      // One pop retires the head of both queues
      if (enq.addr_enq) addr_wp <= ptr_inc(addr_wp);
      if (enq.data_enq) data_wp <= ptr_inc(data_wp);
      if (pair.pop) begin
        addr_rp <= ptr_inc(addr_rp);
        data_rp <= ptr_inc(data_rp);
      end
      addr_cnt <= addr_cnt + (QW+1)'(enq.addr_enq) - (QW+1)'(pair.pop);
      data_cnt <= data_cnt + (QW+1)'(enq.data_enq) - (QW+1)'(pair.pop);
    end
  end

  assign addr_empty    = (addr_cnt == '0);
  assign data_empty    = (data_cnt == '0);
  assign enq.addr_full = (addr_cnt == (QW+1)'(`SP_LSQ_DEPTH));
  assign enq.data_full = (data_cnt == (QW+1)'(`SP_LSQ_DEPTH));

  assign pair.pair_req  = !addr_empty && !data_empty;
  assign pair.head_idx  = addr_q[addr_rp];
  assign pair.head_elem = data_q[data_rp];

  // --------------------
  // Deadlock timer, runs while only one side waits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dl_cnt <= '0;
    end else if (addr_empty ^ data_empty) begin
      if (dl_cnt != CW'(`SP_DL_TIMEOUT)) dl_cnt <= dl_cnt + 1'b1;
    end else begin
      dl_cnt <= '0;
    end
  end

  assign pair.deadlock_hit = (dl_cnt == CW'(`SP_DL_TIMEOUT));

  a_no_enq_full: assert property (@(posedge clk) disable iff (!rst_n)
    !(enq.addr_enq && enq.addr_full) && !(enq.data_enq && enq.data_full));
  a_pop_paired: assert property (@(posedge clk) disable iff (!rst_n)
    pair.pop |-> pair.pair_req);

endmodule

/* src/store_pair_arbiter.sv */
`timescale 1ns/10ps
`include "scratchpad_defs.svh"

module store_pair_arbiter (
  input  logic                     st_done_ready,
  output logic                     st_done_valid,
  output scratchpad_pkg::tag_t     st_done_data,
  output logic                     wr_en,
  output scratchpad_pkg::mem_idx_t wr_idx,
  output scratchpad_pkg::elem_t    wr_elem,
  output logic                     deadlock,
  lane_pair_if.arbiter             lanes [`SP_ST_PORTS]
);
  import scratchpad_pkg::*;

  logic [`SP_ST_PORTS-1:0] req_v;
  logic [`SP_ST_PORTS-1:0] dl_v;
  mem_idx_t                idx_v [`SP_ST_PORTS];
  elem_t                   elem_v [`SP_ST_PORTS];
  tag_t                    sel;

  for (genvar i = 0; i < `SP_ST_PORTS; i++) begin : g_lane
    assign req_v[i]     = lanes[i].pair_req;
    assign dl_v[i]      = lanes[i].deadlock_hit;
    assign idx_v[i]     = lanes[i].head_idx;
    assign elem_v[i]    = lanes[i].head_elem;
    assign lanes[i].pop = wr_en && (sel == tag_t'(i));
  end

  // Lowest requesting tag wins
  always_comb begin
    sel = '0;
    for (int i = `SP_ST_PORTS - 1; i >= 0; i--) begin
      if (req_v[i]) sel = tag_t'(i);
    end
  end

  assign st_done_valid = |req_v;
  assign st_done_data  = sel;

  // Write happens on the same edge that store-done is taken
  assign wr_en   = st_done_valid && st_done_ready;
  assign wr_idx  = idx_v[sel];
  assign wr_elem = elem_v[sel];

  assign deadlock = |dl_v;

endmodule

/* src/store_router.sv */
`timescale 1ns/10ps
`include "scratchpad_defs.svh"

module store_router (
  input  logic                          st_addr_valid,
  output logic                          st_addr_ready,
  input  logic [`SP_TAG_W+`SP_ADDR_W-1:0] st_addr_data,
  input  logic                          st_data_valid,
  output logic                          st_data_ready,
  input  logic [`SP_TAG_W+`SP_ELEM_W-1:0] st_data_data,
  output logic                          st_tag_oob,
  lane_enq_if.router                    lanes [`SP_ST_PORTS]
);
  import scratchpad_pkg::*;

  tag_t                    addr_tag;
  tag_t                    data_tag;
  logic                    addr_tag_ok;
  logic                    data_tag_ok;
  mem_idx_t                addr_idx;
  logic [`SP_ST_PORTS-1:0] addr_full_v;
  logic [`SP_ST_PORTS-1:0] data_full_v;
  logic [`SP_ST_PORTS-1:0] addr_enq_v;
  logic [`SP_ST_PORTS-1:0] data_enq_v;

  assign addr_tag    = st_addr_data[`SP_ADDR_W +: `SP_TAG_W];
  assign data_tag    = st_data_data[`SP_ELEM_W +: `SP_TAG_W];
  assign addr_tag_ok = addr_tag < tag_t'(`SP_ST_PORTS);
  assign data_tag_ok = data_tag < tag_t'(`SP_ST_PORTS);
  assign addr_idx    = mem_idx_t'(st_addr_data[`SP_ADDR_W-1:0]);

  // Ready looks at the tag and the target lane only, never at valid
  assign st_addr_ready = addr_tag_ok && !addr_full_v[addr_tag];
  assign st_data_ready = data_tag_ok && !data_full_v[data_tag];

  assign st_tag_oob = (st_addr_valid && !addr_tag_ok) || (st_data_valid && !data_tag_ok);

  for (genvar i = 0; i < `SP_ST_PORTS; i++) begin : g_lane
    assign addr_full_v[i]     = lanes[i].addr_full;
    assign data_full_v[i]     = lanes[i].data_full;
    assign addr_enq_v[i]      = st_addr_valid && st_addr_ready && (addr_tag == tag_t'(i));
    assign data_enq_v[i]      = st_data_valid && st_data_ready && (data_tag == tag_t'(i));
    assign lanes[i].addr_enq  = addr_enq_v[i];
    assign lanes[i].addr_idx  = addr_idx;
    assign lanes[i].data_enq  = data_enq_v[i];
    assign lanes[i].data_elem = st_data_data[`SP_ELEM_W-1:0];
  end

  a_one_addr_enq: assert final ($onehot0(addr_enq_v));

endmodule
